/* dcache.f */
design/cache_pkg.sv
design/bus_pkg.sv
design/cache_set.sv
design/hit_select.sv
design/cache_ctrl.sv
design/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

/* design/bus_pkg.sv */
package bus_pkg;

    localparam int BUS_ADDR_BITS = 32;
    localparam int BUS_DATA_BITS = 32;
    localparam int BUS_STRB_BITS = BUS_DATA_BITS / 8;

    // read address, burst length fixed by the line size
    typedef struct packed {
        logic [BUS_ADDR_BITS-1:0] araddr;
        logic                     arvalid;
    } bus_ar_t;

    typedef struct packed {
        logic [BUS_DATA_BITS-1:0] rdata;
        logic                     rlast;
        logic                     rvalid;
    } bus_r_t;

    // single beat write, wlast implied
    typedef struct packed {
        logic [BUS_ADDR_BITS-1:0] awaddr;
        logic [BUS_DATA_BITS-1:0] wdata;
        logic [BUS_STRB_BITS-1:0] wstrb;
        logic                     awvalid;
        logic                     wvalid;
    } bus_w_t;

endpackage

/* design/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*, bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     rd,
    input  logic     wr,
    input  addr_t    addr,
    input  word_t    wdata,
    input  strb_t    wstrb,
    input  logic     hit,
    input  way_t     hit_way,
    input  way_t     victim_way,
    input  word_t    hit_word,
    output set_cmd_t cmd,
    output logic     rvalid,
    output word_t    rdata,
    output logic     wdone,
    output logic     busy,
    output bus_ar_t  m_ar,
    input  logic     arready,
    input  bus_r_t   m_r,
    output logic     rready,
    output bus_w_t   m_w,
    input  logic     awready,
    input  logic     wready,
    input  logic     bvalid,
    output logic     bready,
    output addr_t    req_addr
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_ADDR,
        FILL_DATA,
        RESPOND,
        WR_ADDR,
        WR_RESP
    } state_t;

    state_t  state;
    logic    req_wr;
    word_t   req_wdata;
    strb_t   req_wstrb;
    offset_t beat;      // fill beat counter
    logic    aw_done;
    logic    w_done;
    logic    aw_fire;
    logic    w_fire;

    assign aw_fire = m_w.awvalid && awready;
    assign w_fire  = m_w.wvalid && wready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            req_wr  <= 1'b0;
            beat    <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd || wr) begin
                        state  <= LOOKUP;
                        req_wr <= wr;
                    end
                end
                LOOKUP: begin
                    if (req_wr) begin
                        state   <= WR_ADDR;   // write-through, hit or not
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else if (hit) begin
                        state <= RESPOND;
                    end else begin
                        state <= FILL_ADDR;
                        beat  <= '0;
                    end
                end
                FILL_ADDR: begin
                    if (arready) state <= FILL_DATA;
                end
                FILL_DATA: begin
                    if (m_r.rvalid) begin
                        beat <= beat + 1'b1;
                        if (m_r.rlast) state <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;
                WR_ADDR: begin
                    aw_done <= aw_done | aw_fire;
                    w_done  <= w_done | w_fire;
                    if ((aw_done || aw_fire) && (w_done || w_fire)) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (bvalid) state <= RESPOND;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && (rd || wr)) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_wstrb <= wstrb;
        end
    end

    // fill beats go to the victim, the write merge to the hitting way
    always_comb begin
        cmd.index     = req_addr.index;
        cmd.fill_en   = (state == FILL_DATA) && m_r.rvalid;
        cmd.fill_ofs  = beat;
        cmd.fill_word = m_r.rdata;
        cmd.fill_tag  = req_addr.tag;
        cmd.wr_en     = (state == LOOKUP) && req_wr && hit;
        cmd.wr_ofs    = req_addr.offset;
        cmd.wr_data   = req_wdata;
        cmd.wr_strb   = req_wstrb;
        cmd.way       = cmd.wr_en ? hit_way : victim_way;
    end

    assign busy   = (state != IDLE);
    assign rvalid = (state == RESPOND) && !req_wr;
    assign wdone  = (state == RESPOND) && req_wr;
    assign rdata  = hit_word;   // filled line is valid by RESPOND

    assign m_ar.araddr  = {req_addr.tag, req_addr.index, {(OFFSET_BITS + 2){1'b0}}};
    assign m_ar.arvalid = (state == FILL_ADDR);
    assign rready       = (state == FILL_DATA);

    assign m_w.awaddr  = req_addr;
    assign m_w.wdata   = req_wdata;
    assign m_w.wstrb   = req_wstrb;
    assign m_w.awvalid = (state == WR_ADDR) && !aw_done;
    assign m_w.wvalid  = (state == WR_ADDR) && !w_done;
    assign bready      = (state == WR_RESP);

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_ar.arvalid && !arready |=> m_ar.arvalid && $stable(m_ar.araddr));

    a_r_in_fill: assert property (@(posedge clk) disable iff (!arst_n)
        m_r.rvalid |-> state == FILL_DATA);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        state == IDLE |-> !(rd && wr));

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

    // cache geometry
    localparam int NUM_SETS   = 4;
    localparam int LINE_WORDS = 16;
    localparam int WORD_BITS  = 32;
    localparam int STRB_BITS  = 4;
    localparam int MAX_WAYS   = 4;   // width of the way field in commands

    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - 2;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [STRB_BITS-1:0]      strb_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [OFFSET_BITS-1:0]    offset_t;
    typedef logic [$clog2(MAX_WAYS)-1:0] way_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] byte_ofs;
    } addr_t;

    typedef struct packed {
        logic                     valid;
        tag_t                     tag;
        word_t [LINE_WORDS-1:0]   words;   // word 0 in the low bits
    } line_t;

    // broadcast from the controller, each set filters on index
    typedef struct packed {
        index_t  index;
        way_t    way;
        logic    fill_en;
        offset_t fill_ofs;
        word_t   fill_word;
        tag_t    fill_tag;      // taken on the last fill beat
        logic    wr_en;
        offset_t wr_ofs;
        word_t   wr_data;
        strb_t   wr_strb;
    } set_cmd_t;

endpackage

/* design/cache_set.sv */
`timescale 1ns/1ps

module cache_set import cache_pkg::*; #(
    parameter int SET_INDEX = 0,
    parameter int NUM_WAYS  = 4
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  set_cmd_t                   cmd,
    output line_t [NUM_WAYS-1:0]       lines,
    output way_t                       victim_way
);

    logic [NUM_WAYS-1:0]    valid;
    tag_t                   tags  [NUM_WAYS];
    word_t [LINE_WORDS-1:0] data  [NUM_WAYS];
    way_t                   victim_ptr;
    logic                   sel;
    logic                   fill_last;

    assign sel       = (cmd.index == index_t'(SET_INDEX));
    assign fill_last = sel && cmd.fill_en && (cmd.fill_ofs == offset_t'(LINE_WORDS - 1));

    // line payload
    always_ff @(posedge clk) begin
        if (sel && cmd.fill_en) begin
            data[cmd.way][cmd.fill_ofs] <= cmd.fill_word;
            if (fill_last) tags[cmd.way] <= cmd.fill_tag;
        end
        if (sel && cmd.wr_en) begin
            for (int b = 0; b < STRB_BITS; b++) begin
                if (cmd.wr_strb[b])
                    data[cmd.way][cmd.wr_ofs][8*b +: 8] <= cmd.wr_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid      <= '0;
            victim_ptr <= '0;
        end else if (fill_last) begin
            valid[cmd.way] <= 1'b1;
            // round robin, wraps at NUM_WAYS
            if (victim_ptr == way_t'(NUM_WAYS - 1))
                victim_ptr <= '0;
            else
                victim_ptr <= victim_ptr + 1'b1;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            lines[w].valid = valid[w];
            lines[w].tag   = tags[w];
            lines[w].words = data[w];
        end
    end

    assign victim_way = victim_ptr;

    a_fill_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(sel && cmd.fill_en && cmd.wr_en));

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import cache_pkg::*, bus_pkg::*; #(
    parameter int NUM_WAYS = 4
) (
    input  logic    clk,
    input  logic    arst_n,
    // processor side
    input  logic    rd,
    input  logic    wr,
    input  addr_t   addr,
    input  word_t   wdata,
    input  strb_t   wstrb,
    output logic    rvalid,
    output word_t   rdata,
    output logic    wdone,
    output logic    busy,
    // memory bus
    output bus_ar_t m_ar,
    input  logic    arready,
    input  bus_r_t  m_r,
    output logic    rready,
    output bus_w_t  m_w,
    input  logic    awready,
    input  logic    wready,
    input  logic    bvalid,
    output logic    bready
);

    set_cmd_t                           cmd;
    addr_t                              req_addr;
    logic                               hit;
    way_t                               hit_way;
    way_t                               victim_way;
    word_t                              hit_word;
    line_t [NUM_SETS-1:0][NUM_WAYS-1:0] lines_all;
    way_t  [NUM_SETS-1:0]               victim_all;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd         (rd),
        .wr         (wr),
        .addr       (addr),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .hit_word   (hit_word),
        .cmd        (cmd),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .wdone      (wdone),
        .busy       (busy),
        .m_ar       (m_ar),
        .arready    (arready),
        .m_r        (m_r),
        .rready     (rready),
        .m_w        (m_w),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .req_addr   (req_addr)
    );

    for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
        cache_set #(
            .SET_INDEX (s),
            .NUM_WAYS  (NUM_WAYS)
        ) u_set (
            .clk        (clk),
            .arst_n     (arst_n),
            .cmd        (cmd),
            .lines      (lines_all[s]),
            .victim_way (victim_all[s])
        );
    end

    hit_select #(
        .NUM_WAYS (NUM_WAYS)
    ) u_hit (
        .lines_all  (lines_all),
        .req_addr   (req_addr),
        .victim_all (victim_all),
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_word   (hit_word),
        .victim_way (victim_way)
    );

endmodule

/* design/hit_select.sv */
`timescale 1ns/1ps

module hit_select import cache_pkg::*; #(
    parameter int NUM_WAYS = 4
) (
    input  line_t [NUM_SETS-1:0][NUM_WAYS-1:0] lines_all,
    input  addr_t                               req_addr,
    input  way_t  [NUM_SETS-1:0]                victim_all,
    output logic                                hit,
    output way_t                                hit_way,
    output word_t                               hit_word,
    output way_t                                victim_way
);

    line_t [NUM_WAYS-1:0] set_lines;
    logic  [NUM_WAYS-1:0] way_hit;

    assign set_lines  = lines_all[req_addr.index];
    assign victim_way = victim_all[req_addr.index];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = set_lines[w].valid && (set_lines[w].tag == req_addr.tag);
        end
    end

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit      = 1'b1;
                hit_way  = way_t'(w);
                hit_word = set_lines[w].words[req_addr.offset];
            end
        end
    end

    // a line is only filled on a miss, so tags in a set stay unique
    always_comb begin
        a_one_hit: assert final ($onehot0(way_hit))
            else $error("hit_select: more than one way hits in set %0d", req_addr.index);
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module dcache_tb -f dcache.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import cache_pkg::*, bus_pkg::*; ();

    localparam logic [31:0] PATTERN = 32'h5a3c_96e1;
    localparam int          TIMEOUT = 200;
    localparam int          NUM_OPS = 20;

    typedef struct packed {
        logic        is_wr;
        logic [31:0] addr;
        word_t       data;
        strb_t       strb;
        logic        miss;   // expected lookup result
    } op_t;

    logic    clk;
    logic    arst_n;
    logic    rd;
    logic    wr;
    addr_t   addr;
    word_t   wdata;
    strb_t   wstrb;
    logic    rvalid;
    word_t   rdata;
    logic    wdone;
    logic    busy;
    bus_ar_t m_ar;
    bus_r_t  m_r;
    bus_w_t  m_w;
    logic    arready;
    logic    rready;
    logic    awready;
    logic    wready;
    logic    bvalid;
    logic    bready;

    word_t   mirror [logic [29:0]];
    op_t     ops [NUM_OPS];
    int      errors;

    dcache_top #(.NUM_WAYS(4)) dut (.*);
    mem_model #(.PATTERN(PATTERN)) u_mem (.*);

    always #10 clk = ~clk;

    function automatic word_t mirror_word(input logic [31:0] a);
        if (mirror.exists(a[31:2])) return mirror[a[31:2]];
        return {2'b00, a[31:2]} ^ PATTERN;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_table();
        ops[0]  = '{1'b0, 32'h0000_1048, 32'h0, 4'h0, 1'b1};
        ops[1]  = '{1'b0, 32'h0000_107c, 32'h0, 4'h0, 1'b0};   // same line
        ops[2]  = '{1'b1, 32'h0000_1050, 32'hdead_beef, 4'b0101, 1'b0};
        ops[3]  = '{1'b0, 32'h0000_1050, 32'h0, 4'h0, 1'b0};
        ops[4]  = '{1'b1, 32'h0000_2080, 32'h1234_5678, 4'b1111, 1'b1};
        ops[5]  = '{1'b0, 32'h0000_2084, 32'h0, 4'h0, 1'b1};   // write miss did not allocate
        ops[6]  = '{1'b0, 32'h0000_3004, 32'h0, 4'h0, 1'b1};
        ops[7]  = '{1'b0, 32'h0000_3108, 32'h0, 4'h0, 1'b1};
        ops[8]  = '{1'b0, 32'h0000_320c, 32'h0, 4'h0, 1'b1};
        ops[9]  = '{1'b0, 32'h0000_3310, 32'h0, 4'h0, 1'b1};
        ops[10] = '{1'b0, 32'h0000_3414, 32'h0, 4'h0, 1'b1};   // evicts tag 0x30
        ops[11] = '{1'b0, 32'h0000_3018, 32'h0, 4'h0, 1'b1};
        ops[12] = '{1'b0, 32'h0000_341c, 32'h0, 4'h0, 1'b0};
        ops[13] = '{1'b1, 32'h0000_3020, 32'hcafe_f00d, 4'b1100, 1'b0};
        ops[14] = '{1'b0, 32'h0000_3020, 32'h0, 4'h0, 1'b0};
        ops[15] = '{1'b1, 32'h0000_5050, 32'h0000_beef, 4'b0011, 1'b1};
        ops[16] = '{1'b0, 32'h0000_5050, 32'h0, 4'h0, 1'b1};
        ops[17] = '{1'b0, 32'h0000_2080, 32'h0, 4'h0, 1'b0};
        ops[18] = '{1'b1, 32'h0000_1044, 32'h0000_7700, 4'b0010, 1'b0};
        ops[19] = '{1'b0, 32'h0000_1044, 32'h0, 4'h0, 1'b0};
    endtask

    task automatic run_op(input op_t op, output logic timed_out);
        int    cycles;
        int    ar_before;
        int    wr_before;
        word_t exp_word;
        ar_before = u_mem.ar_count;
        wr_before = u_mem.wr_count;
        exp_word  = mirror_word(op.addr);
        if (op.is_wr) begin
            for (int b = 0; b < STRB_BITS; b++) begin
                if (op.strb[b]) exp_word[8*b +: 8] = op.data[8*b +: 8];
            end
            mirror[op.addr[31:2]] = exp_word;
        end
        @(negedge clk);
        addr   = addr_t'(op.addr);
        wdata  = op.data;
        wstrb  = op.strb;
        rd     = !op.is_wr;
        wr     = op.is_wr;
        cycles = 0;
        do begin
            @(negedge clk);
            rd = 1'b0;
            wr = 1'b0;
            cycles++;
        end while (!rvalid && !wdone && cycles < TIMEOUT);
        timed_out = !(rvalid || wdone);
        if (timed_out) begin
            $display("cache gave no rvalid or wdone within %0d cycles", TIMEOUT);
            errors++;
            return;
        end
        if (op.is_wr) begin
            check("wdone", 32'(wdone), 32'd1);
            check("bus write count", u_mem.wr_count, wr_before + 1);
            check("m_w.awaddr", u_mem.last_waddr, op.addr);
            check("m_w.wdata", u_mem.last_wdata, op.data);
            check("m_w.wstrb", 32'(u_mem.last_wstrb), 32'(op.strb));
            check("ar burst count", u_mem.ar_count, ar_before);
        end else begin
            check("rvalid", 32'(rvalid), 32'd1);
            check("rdata", rdata, exp_word);
            check("bus write count", u_mem.wr_count, wr_before);
            if (op.miss) begin
                check("ar burst count", u_mem.ar_count, ar_before + 1);
                check("m_ar.araddr", u_mem.last_araddr, {op.addr[31:6], 6'b0});
            end else begin
                check("ar burst count", u_mem.ar_count, ar_before);
                check("rvalid latency", cycles, 2);
            end
        end
        @(negedge clk);
        check("busy", 32'(busy), 32'd0);   // back to idle after the pulse
    endtask

    initial begin
        logic timed_out;
        int   err_before;
        int   passed;
        int   failed;
        void'($urandom(23));
        clk    = 1'b0;
        arst_n = 1'b0;
        rd     = 1'b0;
        wr     = 1'b0;
        addr   = '0;
        wdata  = '0;
        wstrb  = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check("busy", 32'(busy), 32'd0);
        check("rvalid", 32'(rvalid), 32'd0);
        check("wdone", 32'(wdone), 32'd0);
        check("m_ar.arvalid", 32'(m_ar.arvalid), 32'd0);
        check("m_w.awvalid", 32'(m_w.awvalid), 32'd0);
        check("m_w.wvalid", 32'(m_w.wvalid), 32'd0);
        check("rready", 32'(rready), 32'd0);
        check("bready", 32'(bready), 32'd0);
        foreach (ops[i]) begin
            err_before = errors;
            run_op(ops[i], timed_out);
            if (errors == err_before) passed++;
            else failed++;
            $display("test %0d %s %h: %s", i, ops[i].is_wr ? "wr" : "rd", ops[i].addr,
                     errors == err_before ? "ok" : "failed");
            if (timed_out) break;
        end
        $display("%0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/mem_model.sv */
`timescale 1ns/1ps

// ready with a random 0 to 3 cycle hold-off per request
module ready_delay (
    input  logic clk,
    input  logic arst_n,
    input  logic valid,
    output logic ready
);

    logic [1:0] wait_cnt;
    logic       armed;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready    <= 1'b0;
            wait_cnt <= '0;
            armed    <= 1'b0;
        end else if (valid && ready) begin
            ready <= 1'b0;   // handshake taken
            armed <= 1'b0;
        end else if (valid && !armed) begin
            wait_cnt <= 2'($urandom_range(3, 0));
            armed    <= 1'b1;
        end else if (valid && wait_cnt == 2'd0) begin
            ready <= 1'b1;
        end else if (valid) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

module mem_model import cache_pkg::*, bus_pkg::*; #(
    parameter logic [31:0] PATTERN = 32'h5a3c_96e1
) (
    input  logic    clk,
    input  logic    arst_n,
    input  bus_ar_t m_ar,
    output logic    arready,
    output bus_r_t  m_r,
    input  logic    rready,
    input  bus_w_t  m_w,
    output logic    awready,
    output logic    wready,
    output logic    bvalid,
    input  logic    bready
);

    word_t       mem [logic [29:0]];   // sparse, word addressed
    logic [29:0] burst_base;
    offset_t     beat;
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr;
    word_t       w_data;
    strb_t       w_strb;
    word_t       merged;
    int          ar_count;
    int          wr_count;
    logic [31:0] last_araddr;
    logic [31:0] last_waddr;
    word_t       last_wdata;
    strb_t       last_wstrb;

    function automatic word_t read_word(input logic [29:0] wa);
        return mem.exists(wa) ? mem[wa] : ({2'b00, wa} ^ PATTERN);
    endfunction

    ready_delay u_ar_rdy (.clk(clk), .arst_n(arst_n), .valid(m_ar.arvalid), .ready(arready));
    ready_delay u_aw_rdy (.clk(clk), .arst_n(arst_n), .valid(m_w.awvalid), .ready(awready));
    ready_delay u_w_rdy (.clk(clk), .arst_n(arst_n), .valid(m_w.wvalid), .ready(wready));

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_r         <= '0;
            burst_base  <= '0;
            beat        <= '0;
            aw_got      <= 1'b0;
            w_got       <= 1'b0;
            aw_addr     <= '0;
            w_data      <= '0;
            w_strb      <= '0;
            bvalid      <= 1'b0;
            ar_count    <= 0;
            wr_count    <= 0;
            last_araddr <= '0;
            last_waddr  <= '0;
            last_wdata  <= '0;
            last_wstrb  <= '0;
        end else begin
            if (m_ar.arvalid && arready) begin
                burst_base  <= m_ar.araddr[31:2];
                last_araddr <= m_ar.araddr;
                ar_count    <= ar_count + 1;
                beat        <= '0;
                m_r.rvalid  <= 1'b1;
                m_r.rdata   <= read_word(m_ar.araddr[31:2]);
                m_r.rlast   <= 1'b0;
            end else if (m_r.rvalid && rready) begin
                if (m_r.rlast) begin
                    m_r.rvalid <= 1'b0;
                end else begin
                    beat      <= beat + 1'b1;
                    m_r.rdata <= read_word(burst_base + 30'(beat) + 30'd1);
                    m_r.rlast <= (beat == offset_t'(LINE_WORDS - 2));
                end
            end
            if (m_w.awvalid && awready) begin
                aw_got  <= 1'b1;
                aw_addr <= m_w.awaddr;
            end
            if (m_w.wvalid && wready) begin
                w_got  <= 1'b1;
                w_data <= m_w.wdata;
                w_strb <= m_w.wstrb;
            end
            // both halves in, commit and respond
            if (aw_got && w_got) begin
                merged = read_word(aw_addr[31:2]);
                for (int b = 0; b < STRB_BITS; b++) begin
                    if (w_strb[b]) merged[8*b +: 8] = w_data[8*b +: 8];
                end
                mem[aw_addr[31:2]] = merged;
                aw_got     <= 1'b0;
                w_got      <= 1'b0;
                bvalid     <= 1'b1;
                wr_count   <= wr_count + 1;
                last_waddr <= aw_addr;
                last_wdata <= w_data;
                last_wstrb <= w_strb;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule
